/* compile.f */
ahb_mux_pkg.sv
ahb_addr_if.sv
ahb_input_stage.sv
ahb_arbiter.sv
ahb_bus_mux.sv
ahb_master_mux.sv
tb_ahb_master_mux.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the AHB master multiplexer testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_ahb_master_mux -o sim_tb

# The simulator exits non-zero on a failure, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

/* tb_ahb_master_mux.sv */
/*
  Testbench for the three-to-one AHB master multiplexer
  - Three random AHB masters and a random slave with wait states and errors
  - Cycle model of hold buffers, arbitration, data select and SEQ rules
  - Per-cycle compare of all slave-side and master-side outputs
  - Watchdog over the whole run
*/
`timescale 1ns/1ns

module tb_ahb_master_mux
  import ahb_mux_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int NUM_CYCLES   = 6000;
  localparam int QUIET_CYCLES = 8;
  localparam int MAX_WAIT     = 100;

  logic     HCLK;
  logic     HRESETn;
  integer   seed;

  // Master side, one entry per port
  logic     hsel_s      [NUM_PORTS];
  haddr_t   haddr_s     [NUM_PORTS];
  htrans_e  htrans_s    [NUM_PORTS];
  hsize_t   hsize_s     [NUM_PORTS];
  logic     hwrite_s    [NUM_PORTS];
  logic     hready_s    [NUM_PORTS];
  hprot_t   hprot_s     [NUM_PORTS];
  logic     hlock_s     [NUM_PORTS];
  hdata_t   hwdata_s    [NUM_PORTS];
  logic     hreadyout_s [NUM_PORTS];
  logic     hresp_s     [NUM_PORTS];
  hdata_t   hrdata_s    [NUM_PORTS];

  // Slave side
  logic     hsel_m;
  haddr_t   haddr_m;
  htrans_e  htrans_m;
  hsize_t   hsize_m;
  logic     hwrite_m;
  logic     hready_m;
  hprot_t   hprot_m;
  logic     hlock_m;
  hdata_t   hwdata_m;
  logic     hreadyout_m;
  logic     hresp_m;
  hdata_t   hrdata_m;
  hmaster_t hmaster_m;

  // Reference model state
  // Request bundle is {sel, addr, trans, size, write, prot, lock}
  logic        hold     [NUM_PORTS];
  logic [43:0] held     [NUM_PORTS];
  int          wait_cnt [NUM_PORTS];
  port_sel_t   last_grant;
  port_sel_t   sel_data;
  logic        stalled;
  logic        locked;
  logic        rr;
  logic        idle;
  logic        dphase;
  logic        err_second;

  ahb_master_mux ahb_master_mux_i (
    .HCLK, .HRESETn,
    .HSELS0(hsel_s[0]), .HADDRS0(haddr_s[0]), .HTRANSS0(htrans_s[0]), .HSIZES0(hsize_s[0]),
    .HWRITES0(hwrite_s[0]), .HREADYS0(hready_s[0]), .HPROTS0(hprot_s[0]),
    .HMASTLOCKS0(hlock_s[0]), .HWDATAS0(hwdata_s[0]),
    .HREADYOUTS0(hreadyout_s[0]), .HRESPS0(hresp_s[0]), .HRDATAS0(hrdata_s[0]),
    .HSELS1(hsel_s[1]), .HADDRS1(haddr_s[1]), .HTRANSS1(htrans_s[1]), .HSIZES1(hsize_s[1]),
    .HWRITES1(hwrite_s[1]), .HREADYS1(hready_s[1]), .HPROTS1(hprot_s[1]),
    .HMASTLOCKS1(hlock_s[1]), .HWDATAS1(hwdata_s[1]),
    .HREADYOUTS1(hreadyout_s[1]), .HRESPS1(hresp_s[1]), .HRDATAS1(hrdata_s[1]),
    .HSELS2(hsel_s[2]), .HADDRS2(haddr_s[2]), .HTRANSS2(htrans_s[2]), .HSIZES2(hsize_s[2]),
    .HWRITES2(hwrite_s[2]), .HREADYS2(hready_s[2]), .HPROTS2(hprot_s[2]),
    .HMASTLOCKS2(hlock_s[2]), .HWDATAS2(hwdata_s[2]),
    .HREADYOUTS2(hreadyout_s[2]), .HRESPS2(hresp_s[2]), .HRDATAS2(hrdata_s[2]),
    .HSELM(hsel_m), .HADDRM(haddr_m), .HTRANSM(htrans_m), .HSIZEM(hsize_m),
    .HWRITEM(hwrite_m), .HREADYM(hready_m), .HPROTM(hprot_m), .HMASTLOCKM(hlock_m),
    .HWDATAM(hwdata_m), .HREADYOUTM(hreadyout_m), .HRESPM(hresp_m), .HRDATAM(hrdata_m),
    .HMASTERM(hmaster_m)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
  end

  // ----------------------------------------------------------
  // Failure reporting and value compare
  // ----------------------------------------------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected)
      report_failure($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                               $time, what, actual, expected));
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  // Port 2 asks less often so ports 0 and 1 also meet each other
  task automatic pick_request(input int x, input logic busy);
    logic [31:0] r;
    r = $random(seed);
    hsel_s[x]   = busy & (r[3:0] < ((x == HIGH_PRIO_PORT) ? 4'd6 : 4'd12));
    htrans_s[x] = htrans_e'({r[6] | r[7], r[4]});
    hsize_s[x]  = r[10:8];
    hwrite_s[x] = r[11];
    hprot_s[x]  = r[15:12];
    hlock_s[x]  = (r[19:16] == 4'd0);
    haddr_s[x]  = $random(seed);
    hwdata_s[x] = $random(seed);
  endtask

  task automatic drive_inputs(input logic busy);
    logic [31:0] r;
    int          x;
    r        = $random(seed);
    hrdata_m = $random(seed);
    // Slave is always ready outside a data phase
    // Errors take two cycles
    if (!dphase)
    begin
      hreadyout_m = 1'b1;
      hresp_m     = 1'b0;
    end
    else if (err_second)
    begin
      hreadyout_m = 1'b1;
      hresp_m     = 1'b1;
      err_second  = 1'b0;
    end
    else if (r[4:0] == 5'd0)
    begin
      hreadyout_m = 1'b0;
      hresp_m     = 1'b1;
      err_second  = 1'b1;
    end
    else
    begin
      hreadyout_m = (r[6:5] != 2'b00);
      hresp_m     = 1'b0;
    end
    for (x = 0; x < NUM_PORTS; x++)
    begin
      // A master moves on only after it saw its HREADY high
      if (hready_s[x])
        pick_request(x, busy);
      hready_s[x] = ~hold[x] & (sel_data[x] ? hreadyout_m : 1'b1);
      wait_cnt[x] = hready_s[x] ? 0 : wait_cnt[x] + 1;
      if (wait_cnt[x] > MAX_WAIT)
        report_failure($sformatf("Master port %0d saw HREADYOUTS low for %0d cycles",
                                 x, MAX_WAIT));
    end
  endtask

  // ----------------------------------------------------------
  // Reference model, compare and next state
  // ----------------------------------------------------------
  task automatic check_and_advance();
    logic [43:0] live [NUM_PORTS];
    logic [43:0] eff  [NUM_PORTS];
    logic [43:0] exp_bus;
    port_sel_t   valid;
    port_sel_t   req;
    port_sel_t   grant;
    logic        ready_sel;
    logic        hready_exp;
    logic        active_exp;
    hdata_t      wdata_exp;
    hmaster_t    master_exp;
    logic [5:0]  resp_exp;
    int          x;
    for (x = 0; x < NUM_PORTS; x++)
    begin
      live[x]  = {hsel_s[x], haddr_s[x], htrans_s[x], hsize_s[x], hwrite_s[x],
                  hprot_s[x], hlock_s[x]};
      eff[x]   = hold[x] ? held[x] : live[x];
      valid[x] = hsel_s[x] & htrans_s[x][1] & hready_s[x];
      req[x]   = hold[x] | valid[x];
    end
    if (stalled | locked)
      grant = last_grant;
    else if (req[HIGH_PRIO_PORT])
      grant = 3'b100;
    else if (req[0] & req[1])
      grant = rr ? 3'b001 : 3'b010;
    else
      grant = req;
    exp_bus   = '0;
    ready_sel = 1'b0;
    wdata_exp = '0;
    for (x = 0; x < NUM_PORTS; x++)
    begin
      if (grant[x])
      begin
        exp_bus   |= eff[x];
        ready_sel |= hold[x] | hready_s[x];
      end
      if (sel_data[x])
        wdata_exp |= hwdata_s[x];
      resp_exp[x]     = sel_data[x] & hresp_m;
      resp_exp[x + 3] = hready_s[x];
      check_value(64'(hrdata_s[x]), 64'(hrdata_m), "HRDATAS");
    end
    hready_exp = dphase ? hreadyout_m : (ready_sel | (grant == '0));
    active_exp = exp_bus[43] & exp_bus[10];
    // No SEQ straight after a master switch or an idle cycle
    if (((grant != sel_data) | idle) & (exp_bus[10:9] == 2'b11))
      exp_bus[10:9] = 2'b10;
    case (grant)
      3'b001:  master_exp = 2'd0;
      3'b010:  master_exp = 2'd1;
      3'b100:  master_exp = 2'd2;
      default: master_exp = HMASTER_NONE;
    endcase
    check_value(64'({hsel_m, haddr_m, htrans_m, hsize_m, hwrite_m, hprot_m, hlock_m}),
                64'(exp_bus), "address phase");
    check_value(64'(hready_m), 64'(hready_exp), "HREADYM");
    check_value(64'(hwdata_m), 64'(wdata_exp), "HWDATAM");
    check_value(64'(hmaster_m), 64'(master_exp), "HMASTERM");
    check_value(64'({hreadyout_s[2], hreadyout_s[1], hreadyout_s[0],
                     hresp_s[2], hresp_s[1], hresp_s[0]}), 64'(resp_exp), "port responses");

    // State after the coming edge
    for (x = 0; x < NUM_PORTS; x++)
    begin
      if (valid[x] & ~(grant[x] & hreadyout_m))
        held[x] = live[x];
      hold[x] = (valid[x] | hold[x]) & ~(grant[x] & hreadyout_m);
    end
    idle       = (exp_bus[10:9] == 2'b00) | (idle & ~hready_exp);
    stalled    = active_exp & ~hready_exp;
    last_grant = grant;
    if (hready_exp)
    begin
      locked   = active_exp & exp_bus[0];
      rr       = grant[1] | (rr & ~grant[0]);
      sel_data = grant;
      // Data phase on the slave side
      dphase   = active_exp;
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial
  begin
    int x;
    int cycle;
    seed        = 32'h22048a4a;
    HRESETn     = 1'b0;
    hreadyout_m = 1'b1;
    hresp_m     = 1'b0;
    hrdata_m    = '0;
    for (x = 0; x < NUM_PORTS; x++)
    begin
      hsel_s[x]   = 1'b0;
      haddr_s[x]  = '0;
      htrans_s[x] = TRANS_IDLE;
      hsize_s[x]  = '0;
      hwrite_s[x] = 1'b0;
      hready_s[x] = 1'b1;
      hprot_s[x]  = '0;
      hlock_s[x]  = 1'b0;
      hwdata_s[x] = '0;
      hold[x]     = 1'b0;
      held[x]     = '0;
      wait_cnt[x] = 0;
    end
    last_grant = '0;
    sel_data   = '0;
    stalled    = 1'b0;
    locked     = 1'b0;
    rr         = 1'b0;
    idle       = 1'b0;
    dphase     = 1'b0;
    err_second = 1'b0;
    repeat (2) @(posedge HCLK);
    // First cycles stay quiet to see the reset state of the outputs
    for (cycle = 0; cycle < NUM_CYCLES; cycle++)
    begin
      #2;
      HRESETn = 1'b1;
      drive_inputs(cycle >= QUIET_CYCLES);
      #(CLK_PERIOD - 10);
      check_and_advance();
      @(posedge HCLK);
    end
    $display("RESULT: PASS");
    $finish;
  end

  initial
  begin
    #((NUM_CYCLES + 20) * CLK_PERIOD);
    report_failure("Watchdog expired before the test loop finished");
  end

endmodule

/* ahb_master_mux.sv */
/*
  Three-to-one AHB master multiplexer, top level
  - Three master ports with input stages and hold buffers
  - Arbiter with port 2 priority and round robin on ports 0 and 1
  - One shared AHB slave port through the bus multiplexer
*/
`timescale 1ns/1ns

module ahb_master_mux
  import ahb_mux_pkg::*;
(
  input  logic     HCLK,
  input  logic     HRESETn,

  // Master port 0
  input  logic     HSELS0,
  input  haddr_t   HADDRS0,
  input  htrans_e  HTRANSS0,
  input  hsize_t   HSIZES0,
  input  logic     HWRITES0,
  input  logic     HREADYS0,
  input  hprot_t   HPROTS0,
  input  logic     HMASTLOCKS0,
  input  hdata_t   HWDATAS0,
  output logic     HREADYOUTS0,
  output logic     HRESPS0,
  output hdata_t   HRDATAS0,

  // Master port 1
  input  logic     HSELS1,
  input  haddr_t   HADDRS1,
  input  htrans_e  HTRANSS1,
  input  hsize_t   HSIZES1,
  input  logic     HWRITES1,
  input  logic     HREADYS1,
  input  hprot_t   HPROTS1,
  input  logic     HMASTLOCKS1,
  input  hdata_t   HWDATAS1,
  output logic     HREADYOUTS1,
  output logic     HRESPS1,
  output hdata_t   HRDATAS1,

  // Master port 2, high priority
  input  logic     HSELS2,
  input  haddr_t   HADDRS2,
  input  htrans_e  HTRANSS2,
  input  hsize_t   HSIZES2,
  input  logic     HWRITES2,
  input  logic     HREADYS2,
  input  hprot_t   HPROTS2,
  input  logic     HMASTLOCKS2,
  input  hdata_t   HWDATAS2,
  output logic     HREADYOUTS2,
  output logic     HRESPS2,
  output hdata_t   HRDATAS2,

  // Shared slave port
  output logic     HSELM,
  output haddr_t   HADDRM,
  output htrans_e  HTRANSM,
  output hsize_t   HSIZEM,
  output logic     HWRITEM,
  output logic     HREADYM,
  output hprot_t   HPROTM,
  output logic     HMASTLOCKM,
  output hdata_t   HWDATAM,
  input  logic     HREADYOUTM,
  input  logic     HRESPM,
  input  hdata_t   HRDATAM,
  output hmaster_t HMASTERM
);

  port_sel_t req;
  port_sel_t sel_addr;
  port_sel_t sel_data;

  ahb_addr_if addr_if0_i ();
  ahb_addr_if addr_if1_i ();
  ahb_addr_if addr_if2_i ();

  ahb_input_stage input_stage0_i (
    .HCLK, .HRESETn,
    .hsel(HSELS0), .haddr(HADDRS0), .htrans(HTRANSS0), .hsize(HSIZES0),
    .hwrite(HWRITES0), .hready(HREADYS0), .hprot(HPROTS0), .hmastlock(HMASTLOCKS0),
    .granted(sel_addr[0]), .data_owner(sel_data[0]),
    .hreadyout_m(HREADYOUTM), .hresp_m(HRESPM),
    .req(req[0]), .hreadyout(HREADYOUTS0), .hresp(HRESPS0),
    .addr_bus(addr_if0_i.stage)
  );

  ahb_input_stage input_stage1_i (
    .HCLK, .HRESETn,
    .hsel(HSELS1), .haddr(HADDRS1), .htrans(HTRANSS1), .hsize(HSIZES1),
    .hwrite(HWRITES1), .hready(HREADYS1), .hprot(HPROTS1), .hmastlock(HMASTLOCKS1),
    .granted(sel_addr[1]), .data_owner(sel_data[1]),
    .hreadyout_m(HREADYOUTM), .hresp_m(HRESPM),
    .req(req[1]), .hreadyout(HREADYOUTS1), .hresp(HRESPS1),
    .addr_bus(addr_if1_i.stage)
  );

  ahb_input_stage input_stage2_i (
    .HCLK, .HRESETn,
    .hsel(HSELS2), .haddr(HADDRS2), .htrans(HTRANSS2), .hsize(HSIZES2),
    .hwrite(HWRITES2), .hready(HREADYS2), .hprot(HPROTS2), .hmastlock(HMASTLOCKS2),
    .granted(sel_addr[2]), .data_owner(sel_data[2]),
    .hreadyout_m(HREADYOUTM), .hresp_m(HRESPM),
    .req(req[2]), .hreadyout(HREADYOUTS2), .hresp(HRESPS2),
    .addr_bus(addr_if2_i.stage)
  );

  // Active transfer is HSELM with the top bit of HTRANSM
  ahb_arbiter arbiter_i (
    .HCLK, .HRESETn,
    .req(req), .hready_mux(HREADYM),
    .trans_active(HSELM & HTRANSM[1]), .lock(HMASTLOCKM),
    .sel_addr(sel_addr), .sel_data(sel_data)
  );

  ahb_bus_mux bus_mux_i (
    .HCLK, .HRESETn,
    .port0(addr_if0_i.mux), .port1(addr_if1_i.mux), .port2(addr_if2_i.mux),
    .hwdata0(HWDATAS0), .hwdata1(HWDATAS1), .hwdata2(HWDATAS2),
    .sel_addr(sel_addr), .sel_data(sel_data), .hreadyout_m(HREADYOUTM),
    .hsel_m(HSELM), .haddr_m(HADDRM), .htrans_m(HTRANSM), .hsize_m(HSIZEM),
    .hwrite_m(HWRITEM), .hready_m(HREADYM), .hprot_m(HPROTM), .hlock_m(HMASTLOCKM),
    .hwdata_m(HWDATAM), .hmaster_m(HMASTERM)
  );

  // Read data goes to every master, only the owner samples it
  assign HRDATAS0 = HRDATAM;
  assign HRDATAS1 = HRDATAM;
  assign HRDATAS2 = HRDATAM;

endmodule

/* ahb_bus_mux.sv */
/*
  Bus multiplexer towards the shared AHB slave port
  - Address-phase fields by address select, write data by data select
  - HREADY generation and SEQ suppression after a switch or idle
  - Master index encoding
*/
`timescale 1ns/1ns

module ahb_bus_mux
  import ahb_mux_pkg::*;
(
  input  logic      HCLK,
  input  logic      HRESETn,
  ahb_addr_if.mux   port0,
  ahb_addr_if.mux   port1,
  ahb_addr_if.mux   port2,
  input  hdata_t    hwdata0,
  input  hdata_t    hwdata1,
  input  hdata_t    hwdata2,
  input  port_sel_t sel_addr,
  input  port_sel_t sel_data,
  input  logic      hreadyout_m,
  output logic      hsel_m,
  output haddr_t    haddr_m,
  output htrans_e   htrans_m,
  output hsize_t    hsize_m,
  output logic      hwrite_m,
  output logic      hready_m,
  output hprot_t    hprot_m,
  output logic      hlock_m,
  output hdata_t    hwdata_m,
  output hmaster_t  hmaster_m
);

  logic [1:0] trans_sel;
  logic       ready_sel;
  logic       active_q;
  logic       idle_q;
  logic       suppress_seq;

  // ----------------------------------------------------------
  // Address phase as AND-OR over the one-hot select
  // ----------------------------------------------------------
  assign hsel_m    = (sel_addr[0] & port0.sel) |
                     (sel_addr[1] & port1.sel) |
                     (sel_addr[2] & port2.sel);
  assign haddr_m   = ({32{sel_addr[0]}} & port0.addr) |
                     ({32{sel_addr[1]}} & port1.addr) |
                     ({32{sel_addr[2]}} & port2.addr);
  assign trans_sel = ({2{sel_addr[0]}} & port0.trans) |
                     ({2{sel_addr[1]}} & port1.trans) |
                     ({2{sel_addr[2]}} & port2.trans);
  assign hwrite_m  = (sel_addr[0] & port0.write) |
                     (sel_addr[1] & port1.write) |
                     (sel_addr[2] & port2.write);
  assign hsize_m   = ({3{sel_addr[0]}} & port0.size) |
                     ({3{sel_addr[1]}} & port1.size) |
                     ({3{sel_addr[2]}} & port2.size);
  assign hprot_m   = ({4{sel_addr[0]}} & port0.prot) |
                     ({4{sel_addr[1]}} & port1.prot) |
                     ({4{sel_addr[2]}} & port2.prot);
  assign hlock_m   = (sel_addr[0] & port0.lock) |
                     (sel_addr[1] & port1.lock) |
                     (sel_addr[2] & port2.lock);
  assign ready_sel = (sel_addr[0] & port0.ready) |
                     (sel_addr[1] & port1.ready) |
                     (sel_addr[2] & port2.ready);

  // Slave ready during a live data phase, else the owning master's view
  assign hready_m = active_q ? hreadyout_m : (ready_sel | (sel_addr == '0));

  // Data phase in progress on the slave side
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      active_q <= 1'b0;
    else if (hready_m)
      active_q <= hsel_m & trans_sel[1];
  end

  // ----------------------------------------------------------
  // SEQ suppression
  // ----------------------------------------------------------

  // Set after IDLE on the bus, cleared at the next accepted address phase
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      idle_q <= 1'b0;
    else
      idle_q <= (htrans_m == TRANS_IDLE) | (idle_q & ~hready_m);
  end

  assign suppress_seq = (sel_addr != sel_data) | idle_q;

  always_comb
  begin
    htrans_m = htrans_e'(trans_sel);
    if (suppress_seq && (htrans_m == TRANS_SEQ))
      htrans_m = TRANS_NONSEQ;
  end

  // Write data follows the owner of the data phase
  assign hwdata_m = ({32{sel_data[0]}} & hwdata0) |
                    ({32{sel_data[1]}} & hwdata1) |
                    ({32{sel_data[2]}} & hwdata2);

  always_comb
  begin
    case (sel_addr)
      3'b001:  hmaster_m = 2'd0;
      3'b010:  hmaster_m = 2'd1;
      3'b100:  hmaster_m = 2'd2;
      default: hmaster_m = HMASTER_NONE;
    endcase
  end

endmodule

/* ahb_arbiter.sv */
/*
  Arbiter for three AHB master ports
  - Port 2 fixed high priority, ports 0 and 1 round robin
  - Grant held for a stalled announced transfer or a locked data phase
  - Data-phase select register
*/
`timescale 1ns/1ns

module ahb_arbiter
  import ahb_mux_pkg::*;
(
  input  logic      HCLK,
  input  logic      HRESETn,
  input  port_sel_t req,
  input  logic      hready_mux,
  input  logic      trans_active,
  input  logic      lock,
  output port_sel_t sel_addr,
  output port_sel_t sel_data
);

  port_sel_t grant;
  port_sel_t last_grant_q;
  port_sel_t sel_data_q;
  logic      stalled_q;
  logic      locked_q;
  logic      rr_q;
  logic      rr_nxt;

  // ----------------------------------------------------------
  // Hold conditions
  // ----------------------------------------------------------

  // Transfer on the bus last cycle that the slave side did not take
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      stalled_q    <= 1'b0;
      last_grant_q <= '0;
    end
    else
    begin
      stalled_q    <= trans_active & ~hready_mux;
      last_grant_q <= grant;
    end
  end

  // Locked transfer moving into its data phase
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      locked_q <= 1'b0;
    else if (hready_mux)
      locked_q <= trans_active & lock;
  end

  // ----------------------------------------------------------
  // Round robin between ports 0 and 1
  // ----------------------------------------------------------

  // Set by a port 1 grant, cleared by a port 0 grant, kept on port 2
  assign rr_nxt = grant[1] | (rr_q & ~grant[0]);

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      rr_q <= 1'b0;
    else if (hready_mux)
      rr_q <= rr_nxt;
  end

  // ----------------------------------------------------------
  // Grant selection
  // ----------------------------------------------------------
  always_comb
  begin
    grant = '0;
    if (stalled_q | locked_q)
      grant = last_grant_q;
    else if (req[HIGH_PRIO_PORT])
      grant[HIGH_PRIO_PORT] = 1'b1;
    else if (req[0] & req[1])
    begin
      // Port 1 went last, so port 0 goes now
      grant[0] = rr_q;
      grant[1] = ~rr_q;
    end
    else
      grant = req;
  end

  // Owner of the data phase follows the accepted address phase
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      sel_data_q <= '0;
    else if (hready_mux)
      sel_data_q <= grant;
  end

  assign sel_addr = grant;
  assign sel_data = sel_data_q;

endmodule

/* ahb_input_stage.sv */
/*
  Input stage for one AHB master port
  - Hold buffer for an address phase that cannot be passed on at once
  - Bus request towards the arbiter
  - Ready and response return to the master
*/
`timescale 1ns/1ns

module ahb_input_stage
  import ahb_mux_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,
  input  logic    hsel,
  input  haddr_t  haddr,
  input  htrans_e htrans,
  input  hsize_t  hsize,
  input  logic    hwrite,
  input  logic    hready,
  input  hprot_t  hprot,
  input  logic    hmastlock,
  input  logic    granted,
  input  logic    data_owner,
  input  logic    hreadyout_m,
  input  logic    hresp_m,
  output logic    req,
  output logic    hreadyout,
  output logic    hresp,
  ahb_addr_if.stage addr_bus
);

  logic    trans_valid;
  logic    taken;
  logic    input_hold;
  logic    hold_q;
  haddr_t  addr_q;
  htrans_e trans_q;
  logic    write_q;
  hsize_t  size_q;
  hprot_t  prot_q;
  logic    lock_q;

  // New transfer from the master this cycle
  assign trans_valid = hsel & htrans[1] & hready;

  // Slave side accepts this port's address phase at the coming edge
  assign taken = granted & hreadyout_m;

  assign input_hold = trans_valid & ~taken;

  // Hold flag stays up until the buffered request goes out
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      hold_q <= 1'b0;
    else
      hold_q <= input_hold | (hold_q & ~taken);
  end

  // Hold buffer
  always_ff @(posedge HCLK)
  begin
    if (input_hold)
    begin
      addr_q  <= haddr;
      trans_q <= htrans;
      write_q <= hwrite;
      size_q  <= hsize;
      prot_q  <= hprot;
      lock_q  <= hmastlock;
    end
  end

  // ----------------------------------------------------------
  // Request towards the bus multiplexer
  // ----------------------------------------------------------
  assign addr_bus.sel   = hold_q | hsel;
  assign addr_bus.addr  = hold_q ? addr_q  : haddr;
  assign addr_bus.trans = hold_q ? trans_q : htrans;
  assign addr_bus.write = hold_q ? write_q : hwrite;
  assign addr_bus.size  = hold_q ? size_q  : hsize;
  assign addr_bus.prot  = hold_q ? prot_q  : hprot;
  assign addr_bus.lock  = hold_q ? lock_q  : hmastlock;
  // A buffered request is always presented as ready
  assign addr_bus.ready = hold_q | hready;

  assign req = hold_q | trans_valid;

  // Wait state while buffering, slave response while owning the data phase
  assign hreadyout = ~hold_q & (data_owner ? hreadyout_m : 1'b1);
  assign hresp     = data_owner ? hresp_m : HRESP_OKAY;

endmodule

/* ahb_addr_if.sv */
/*
  Address-phase request of one master port
  - Driven by the input stage, either live or from the hold buffer
  - Read by the bus multiplexer
*/
`timescale 1ns/1ns

interface ahb_addr_if
  import ahb_mux_pkg::*;
();

  logic    sel;
  haddr_t  addr;
  htrans_e trans;
  logic    write;
  hsize_t  size;
  hprot_t  prot;
  logic    lock;
  logic    ready;

  modport stage (
    output sel, addr, trans, write, size, prot, lock, ready
  );

  modport mux (
    input  sel, addr, trans, write, size, prot, lock, ready
  );

endinterface

/* ahb_mux_pkg.sv */
/*
  Shared definitions for the three-to-one AHB master multiplexer
  - AHB field types for address, data, size and protection
  - Transfer type enum and one-hot port select type
  - Master index type and the fixed constants of the design
*/
package ahb_mux_pkg;

  // ----------------------------------------------------------
  // Port counts and fixed indices
  // ----------------------------------------------------------
  localparam int NUM_PORTS      = 3;
  localparam int HIGH_PRIO_PORT = 2;

  // ----------------------------------------------------------
  // AHB field types
  // ----------------------------------------------------------
  typedef logic [31:0] haddr_t;
  typedef logic [31:0] hdata_t;
  typedef logic [2:0]  hsize_t;
  typedef logic [3:0]  hprot_t;

  // Transfer type encoding as defined by AHB
  typedef enum logic [1:0] {
    TRANS_IDLE   = 2'b00,
    TRANS_BUSY   = 2'b01,
    TRANS_NONSEQ = 2'b10,
    TRANS_SEQ    = 2'b11
  } htrans_e;

  // One-hot select, bit n is master port n
  typedef logic [NUM_PORTS-1:0] port_sel_t;

  // Master index shown on HMASTERM
  typedef logic [1:0] hmaster_t;

  // Index shown when no port owns the address phase
  localparam hmaster_t HMASTER_NONE = 2'd3;

  // Response value for a port that is not in its data phase
  localparam logic HRESP_OKAY = 1'b0;

endpackage
